/* tests/async_fifo_trace.txt */
# W <strobes> <accepted> <bytes>  and  R <strobes> <accepted> <expected bytes>, hex data
# D <cycles> <expected count>  waits, then checks the flags against the count
D 8 0
R 3 0
W 4 4 11 22 33 44
D 8 4
R 4 4 11 22 33 44
D 8 0
W 3 3 a1 a2 a3
D 8 3
R 2 2 a1 a2
D 8 1
R 2 1 a3
D 8 0
W 15 15 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e
D 8 15
W 3 1 5f 60 61
D 8 16
W 2 0 62 63
D 8 16
R 16 16 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
D 8 0
W 12 12 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb
D 8 12
R 12 12 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb
D 8 0
W 10 10 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9
D 8 10
R 12 10 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9
D 8 0

/* sources.f */
rtl/async_fifo_pkg.sv
rtl/fifo_ram_if.sv
rtl/dualport_ram_async.sv
rtl/gray_ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
tests/tb_clock_gen.sv
tests/async_fifo_sva.sv
tests/async_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module async_fifo_tb \
  -o async_fifo_sim

./obj_dir/async_fifo_sim

/* tests/async_fifo_tb.sv */
`default_nettype none

module async_fifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam string TRACE_FILE = "tests/async_fifo_trace.txt";

  logic                                  wr_clk;
  logic                                  wr_rst_n;
  logic                                  wr_en;
  logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data;
  logic                                  rd_clk;
  logic                                  rd_rst_n;
  logic                                  rd_en;
  logic [async_fifo_pkg::DATA_WIDTH-1:0] rd_data;
  logic                                  full;
  logic                                  afull;
  logic                                  empty;
  logic                                  aempty;

  logic [async_fifo_pkg::DATA_WIDTH-1:0] model_q[$];
  logic [async_fifo_pkg::DATA_WIDTH-1:0] last_rd_data;
  logic [31:0]                           lfsr_state;
  int                                    trace_fd;
  int                                    cycle_cnt = 0;
  int                                    cycle_limit = 0;

  tb_clock_gen #(.HALF_PERIOD(50)) i_rd_clk_gen (.clk(rd_clk));
  tb_clock_gen #(.HALF_PERIOD(35)) i_wr_clk_gen (.clk(wr_clk));

  async_fifo i_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Galois form, x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_gap(output int gap);
    int gap_v;
    gap_v = 0;
    for (int i = 0; i < 2; i++) begin
      gap_v = (gap_v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    gap = gap_v;
  endtask

  task automatic compare_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Check failed: %s", what);
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Test failures found");
    $fatal(1, "%s", why);
  endtask

  task automatic write_burst(input int n, input int k);
    int                                    accepted;
    int                                    gap;
    int                                    rc;
    logic                                  was_full;
    logic [async_fifo_pkg::DATA_WIDTH-1:0] b;
    accepted = 0;
    for (int i = 0; i < n; i++) begin
      rc = $fscanf(trace_fd, "%h", b);
      if (rc != 1) begin
        abort_run("A write burst in the trace is missing data bytes");
      end
      next_gap(gap);
      repeat (gap) @(posedge wr_clk);
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= b;
      @(negedge wr_clk);
      was_full = full;
      @(posedge wr_clk);
      wr_en <= 1'b0;
      if (!was_full) begin
        model_q.push_back(b);
        accepted++;
      end
    end
    compare_val(accepted, k, "accepted writes in burst");
  endtask

  task automatic read_burst(input int n, input int k);
    int                                    accepted;
    int                                    gap;
    int                                    rc;
    logic                                  was_empty;
    logic [async_fifo_pkg::DATA_WIDTH-1:0] exp_file;
    logic [async_fifo_pkg::DATA_WIDTH-1:0] exp_model;
    accepted = 0;
    for (int i = 0; i < n; i++) begin
      next_gap(gap);
      repeat (gap) @(posedge rd_clk);
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(negedge rd_clk);
      was_empty = empty;
      @(posedge rd_clk);
      rd_en <= 1'b0;
      // rd_data settles on the edge that took the read.
      @(negedge rd_clk);
      if (!was_empty) begin
        accepted++;
        rc = $fscanf(trace_fd, "%h", exp_file);
        if (rc != 1 || accepted > k || model_q.size() == 0) begin
          abort_run("A read was accepted that neither the trace nor the model expects");
        end
        exp_model = model_q.pop_front();
        compare_val(32'(exp_model), 32'(exp_file), "model word against trace");
        compare_val(32'(rd_data), 32'(exp_model), "read data");
        last_rd_data = exp_model;
      end else begin
        compare_val(32'(rd_data), 32'(last_rd_data), "read data held over a dropped read");
      end
    end
    compare_val(accepted, k, "accepted reads in burst");
  endtask

  task automatic drain_check(input int cycles, input int count);
    if (cycles < 6) begin
      abort_run("A drain wait in the trace is shorter than six cycles");
    end
    // The read clock is the slower one, so this covers both domains.
    repeat (cycles) @(posedge rd_clk);
    @(negedge rd_clk);
    compare_val(model_q.size(), count, "model count against trace");
    compare_val(32'(empty), 32'(model_q.size() == 0), "empty after drain");
    compare_val(32'(aempty), 32'(model_q.size() <= async_fifo_pkg::FIFO_AEMPTY),
                "aempty after drain");
    @(negedge wr_clk);
    compare_val(32'(full), 32'(model_q.size() == async_fifo_pkg::FIFO_DEPTH), "full after drain");
    compare_val(32'(afull), 32'(model_q.size() >= async_fifo_pkg::FIFO_AFULL),
                "afull after drain");
  endtask

  always @(posedge rd_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: the trace did not finish within %0d rd_clk cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "Timeout, the run was stopped");
    end
  end

  initial begin
    int                rc;
    int                c;
    int                entries;
    int                n;
    int                k;
    logic              line_start;
    logic [7:0]        ch;
    logic [7:0]        op;
    logic [8*200-1:0]  rest;
    wr_en        <= 1'b0;
    wr_data      <= '0;
    rd_en        <= 1'b0;
    wr_rst_n     <= 1'b0;
    rd_rst_n     <= 1'b0;
    lfsr_state   = 32'he996d1e0;
    last_rd_data = '0;

    // Count operation lines to size the timeout.
    trace_fd = $fopen(TRACE_FILE, "r");
    if (trace_fd == 0) begin
      abort_run("Cannot open the trace file tests/async_fifo_trace.txt");
    end
    entries    = 0;
    line_start = 1'b1;
    c = $fgetc(trace_fd);
    while (c != -1) begin
      ch = c[7:0];
      if (line_start && ch != "#" && ch != "\n" && ch != " ") begin
        entries++;
      end
      line_start = (ch == "\n");
      c = $fgetc(trace_fd);
    end
    $fclose(trace_fd);
    cycle_limit = 40 * entries + 200;
    trace_fd = $fopen(TRACE_FILE, "r");

    repeat (8) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    @(negedge rd_clk);
    compare_val(32'(empty), 32'd1, "empty after reset");
    compare_val(32'(aempty), 32'd1, "aempty after reset");
    @(negedge wr_clk);
    compare_val(32'(full), 32'd0, "full after reset");
    compare_val(32'(afull), 32'd0, "afull after reset");

    rc = $fscanf(trace_fd, "%s", op);
    while (rc == 1) begin
      if (op == "#") begin
        rc = $fgets(rest, trace_fd);
      end else if (op == "W" && $fscanf(trace_fd, "%d %d", n, k) == 2) begin
        write_burst(n, k);
      end else if (op == "R" && $fscanf(trace_fd, "%d %d", n, k) == 2) begin
        read_burst(n, k);
      end else if (op == "D" && $fscanf(trace_fd, "%d %d", n, k) == 2) begin
        drain_check(n, k);
      end else begin
        abort_run("The trace holds an unknown or malformed operation");
      end
      rc = $fscanf(trace_fd, "%s", op);
    end
    $fclose(trace_fd);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/async_fifo_sva.sv */
`default_nettype none

module async_fifo_sva (
  input wire logic                                wr_clk,
  input wire logic                                wr_rst_n,
  input wire logic                                wr_en,
  input wire logic                                rd_clk,
  input wire logic                                rd_rst_n,
  input wire logic                                rd_en,
  input wire logic                                full,
  input wire logic                                afull,
  input wire logic                                empty,
  input wire logic                                aempty,
  input wire logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_gray,
  input wire logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_gray
);

  timeunit 1ns;
  timeprecision 100ps;

  // Flags only rise on an edge that took a strobe on their own side.
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n) $rose(full) |-> $past(wr_en))
    else $error("full rose without a write strobe");
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n) $rose(empty) |-> $past(rd_en))
    else $error("empty rose without a read strobe");

  // One bit per edge, so the far side never sees a torn pointer.
  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
    else $error("write Gray pointer changed more than one bit");
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1)
    else $error("read Gray pointer changed more than one bit");

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull)
    else $error("full high while afull low");
  assert property (@(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty)
    else $error("empty high while aempty low");

endmodule

bind async_fifo async_fifo_sva i_sva (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .wr_en       (wr_en),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .rd_en       (rd_en),
  .full        (full),
  .afull       (afull),
  .empty       (empty),
  .aempty      (aempty),
  .wr_ptr_gray (wr_ptr_gray),
  .rd_ptr_gray (rd_ptr_gray)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD = 50
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running, starts low.
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* rtl/async_fifo.sv */
`default_nettype none

module async_fifo (
  input  wire logic                                  wr_clk,
  input  wire logic                                  wr_rst_n,
  input  wire logic                                  wr_en,
  input  wire logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data,
  input  wire logic                                  rd_clk,
  input  wire logic                                  rd_rst_n,
  input  wire logic                                  rd_en,
  output logic      [async_fifo_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                                       full,
  output logic                                       afull,
  output logic                                       empty,
  output logic                                       aempty
);

  logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_gray;
  logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_gray;
  logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_bin_rsync;
  logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_bin_wsync;

  fifo_ram_if i_ram_if ();

  fifo_wr_ctrl i_wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .wr_data          (wr_data),
    .rd_ptr_bin_wsync (rd_ptr_bin_wsync),
    .ram              (i_ram_if.wr),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  fifo_rd_ctrl i_rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_bin_rsync (wr_ptr_bin_rsync),
    .ram              (i_ram_if.rd),
    .rd_ptr_gray      (rd_ptr_gray),
    .empty            (empty),
    .aempty           (aempty)
  );

  // Write pointer into the read domain.
  gray_ptr_sync i_wr_ptr_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .ptr_gray  (wr_ptr_gray),
    .ptr_bin   (wr_ptr_bin_rsync)
  );

  // Read pointer into the write domain.
  gray_ptr_sync i_rd_ptr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .ptr_gray  (rd_ptr_gray),
    .ptr_bin   (rd_ptr_bin_wsync)
  );

  dualport_ram_async i_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram      (i_ram_if.mem)
  );

  assign rd_data = i_ram_if.rd_data;

endmodule

`default_nettype wire

/* rtl/fifo_rd_ctrl.sv */
`default_nettype none

module fifo_rd_ctrl (
  input  wire logic                                rd_clk,
  input  wire logic                                rd_rst_n,
  input  wire logic                                rd_en,
  input  wire logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_bin_rsync,
  fifo_ram_if.rd                                   ram,
  output logic      [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_gray,
  output logic                                     empty,
  output logic                                     aempty
);

  logic                                rd_vld;
  logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr;
  logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_nxt;
  logic [async_fifo_pkg::ADDR_WIDTH:0] fill_nxt;
  logic                                empty_nxt;
  logic                                aempty_nxt;

  // Reads while empty are dropped.
  assign rd_vld     = rd_en && !empty;
  assign rd_ptr_nxt = rd_ptr + (async_fifo_pkg::ADDR_WIDTH + 1)'(rd_vld);

  // Empty when the pointers match, wrap bit included.
  assign empty_nxt  = (rd_ptr_nxt == wr_ptr_bin_rsync);
  assign fill_nxt   = wr_ptr_bin_rsync - rd_ptr_nxt;
  assign aempty_nxt =
    (fill_nxt <= (async_fifo_pkg::ADDR_WIDTH + 1)'(async_fifo_pkg::FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_ptr_nxt ^ (rd_ptr_nxt >> 1);
      empty       <= empty_nxt;
      aempty      <= aempty_nxt;
    end
  end

  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr[async_fifo_pkg::ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

/* rtl/fifo_wr_ctrl.sv */
`default_nettype none

module fifo_wr_ctrl (
  input  wire logic                                wr_clk,
  input  wire logic                                wr_rst_n,
  input  wire logic                                wr_en,
  input  wire logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data,
  input  wire logic [async_fifo_pkg::ADDR_WIDTH:0] rd_ptr_bin_wsync,
  fifo_ram_if.wr                                   ram,
  output logic      [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_gray,
  output logic                                     full,
  output logic                                     afull
);

  logic                                wr_vld;
  logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr;
  logic [async_fifo_pkg::ADDR_WIDTH:0] wr_ptr_nxt;
  logic [async_fifo_pkg::ADDR_WIDTH:0] fill_nxt;
  logic                                full_nxt;
  logic                                afull_nxt;

  // Writes while full are dropped.
  assign wr_vld     = wr_en && !full;
  assign wr_ptr_nxt = wr_ptr + (async_fifo_pkg::ADDR_WIDTH + 1)'(wr_vld);

  // Full when only the wrap bit differs.
  assign full_nxt  = (wr_ptr_nxt == {~rd_ptr_bin_wsync[async_fifo_pkg::ADDR_WIDTH],
                                     rd_ptr_bin_wsync[async_fifo_pkg::ADDR_WIDTH-1:0]});
  assign fill_nxt  = wr_ptr_nxt - rd_ptr_bin_wsync;
  assign afull_nxt = (fill_nxt >= (async_fifo_pkg::ADDR_WIDTH + 1)'(async_fifo_pkg::FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_ptr_nxt ^ (wr_ptr_nxt >> 1);
      full        <= full_nxt;
      afull       <= afull_nxt;
    end
  end

  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr[async_fifo_pkg::ADDR_WIDTH-1:0];
  assign ram.wr_data = wr_data;

endmodule

`default_nettype wire

/* rtl/gray_ptr_sync.sv */
`default_nettype none

module gray_ptr_sync (
  input  wire logic                                dst_clk,
  input  wire logic                                dst_rst_n,
  input  wire logic [async_fifo_pkg::ADDR_WIDTH:0] ptr_gray,
  output logic      [async_fifo_pkg::ADDR_WIDTH:0] ptr_bin
);

  logic [async_fifo_pkg::ADDR_WIDTH:0] sync_q1;
  logic [async_fifo_pkg::ADDR_WIDTH:0] sync_q2;

  // Two-flop chain into the destination clock.
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray;
      sync_q2 <= sync_q1;
    end
  end

  // Gray to binary, MSB down.
  always_comb begin
    ptr_bin[async_fifo_pkg::ADDR_WIDTH] = sync_q2[async_fifo_pkg::ADDR_WIDTH];
    for (int i = async_fifo_pkg::ADDR_WIDTH - 1; i >= 0; i--) begin
      ptr_bin[i] = ptr_bin[i+1] ^ sync_q2[i];
    end
  end

endmodule

`default_nettype wire

/* rtl/dualport_ram_async.sv */
`default_nettype none

module dualport_ram_async (
  input  wire logic  wr_clk,
  input  wire logic  rd_clk,
  input  wire logic  rd_rst_n,
  fifo_ram_if.mem    ram
);

  logic [async_fifo_pkg::DATA_WIDTH-1:0] mem_array [async_fifo_pkg::FIFO_DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem_array[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Registered read port, holds its word until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ram.rd_data <= '0;
    end else if (ram.rd_en) begin
      ram.rd_data <= mem_array[ram.rd_addr];
    end
  end

endmodule

`default_nettype wire

/* rtl/fifo_ram_if.sv */
`default_nettype none

interface fifo_ram_if;

  // Write port, owned by the write clock domain.
  logic                                  wr_en;
  logic [async_fifo_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [async_fifo_pkg::DATA_WIDTH-1:0] wr_data;

  // Read port, owned by the read clock domain.
  logic                                  rd_en;
  logic [async_fifo_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [async_fifo_pkg::DATA_WIDTH-1:0] rd_data;

  modport wr (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport rd (
    output rd_en,
    output rd_addr
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

/* rtl/async_fifo_pkg.sv */
`default_nettype none

package async_fifo_pkg;

  // Width of one stored word.
  localparam int DATA_WIDTH = 8;

  // Number of words held. Must be a power of two for the pointer logic.
  localparam int FIFO_DEPTH = 16;

  // Memory address width. Pointers carry one extra wrap bit on top.
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Almost-full when the stored count reaches this value.
  localparam int FIFO_AFULL = 15;

  // Almost-empty while the stored count is at or below this value.
  localparam int FIFO_AEMPTY = 1;

endpackage

`default_nettype wire
